//--- verification/ctrl_testdata.txt
# wr rd addr  portid rem_epid data     byte_en has_time time             exp_status exp_data
# all hex; addr is a byte address, register index is addr/4, bank holds 16 words
1 0 00000 005 0010 0badc0de f 0 0000000000000000 0 0badc0de
1 0 00004 005 0010 12345678 f 0 0000000000000000 0 12345678
0 1 00004 005 0010 00000000 f 0 0000000000000000 0 12345678
0 1 00024 005 0010 00000000 f 0 0000000000000000 0 00000000
1 0 00008 005 0010 11223344 f 0 0000000000000000 0 11223344
1 0 00008 005 0010 aabbccdd 5 0 0000000000000000 0 aabbccdd
0 1 00008 005 0010 00000000 f 0 0000000000000000 0 11bb33dd
1 0 0000c 005 0010 cafef00d f 0 0000000000000000 0 cafef00d
1 1 0000c 005 0010 00001234 3 0 0000000000000000 0 cafe1234
0 1 0000c 005 0010 00000000 f 0 0000000000000000 0 cafe1234
1 0 00010 005 0010 deadbeef f 1 0123456789abcdef 0 deadbeef
0 1 00010 005 0010 00000000 f 1 fedcba9876543210 0 deadbeef
0 1 00010 005 0010 00000000 f 0 0000000000000000 0 deadbeef
1 0 00014 005 0010 00000000 f 0 0000000000000000 0 00000000
1 1 00014 005 0010 5a5aa5a5 c 1 ffffffffffffffff 0 5a5a0000
1 0 00004 006 0010 ffffffff f 0 0000000000000000 1 00000000
0 1 00004 005 0010 00000000 f 0 0000000000000000 0 12345678
1 0 00004 005 0011 ffffffff f 0 0000000000000000 1 00000000
0 1 00004 000 0010 00000000 f 0 0000000000000000 1 00000000
0 1 00004 005 0010 00000000 f 0 0000000000000000 0 12345678
1 0 00040 005 0010 ffffffff f 0 0000000000000000 1 00000000
0 1 00000 005 0010 00000000 f 0 0000000000000000 0 0badc0de
0 1 ffffc 005 0010 00000000 f 0 0000000000000000 1 00000000
1 1 00008 005 1234 ffffffff f 1 00000000000000aa 1 00000000
0 1 00008 005 0010 00000000 f 0 0000000000000000 0 11bb33dd
1 0 0003c 005 0010 89abcdef f 0 0000000000000000 0 89abcdef
1 0 0003c 005 0010 00000000 0 0 0000000000000000 0 00000000
0 1 0003c 005 0010 00000000 f 0 0000000000000000 0 89abcdef

//--- verilog.f
src/ctrl_pkg.sv
src/ctrl_reg_bank.sv
src/ctrl_master.sv
src/ctrl_responder.sv
src/ctrl_loopback_top.sv
verification/ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the loopback control path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module ctrl_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vctrl_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
else
  exit 1
fi

//--- verification/ctrl_tb.sv
// Testbench for the loopback control path, replaying request vectors from a data file
`default_nettype none

module ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------
  // Run limits
  // ------------------------------
  // The vector list is replayed so the 6-bit sequence counters wrap
  localparam int NUM_PASSES      = 3;
  localparam int CYCLES_PER_TEST = 40;
  localparam int CYCLE_MARGIN    = 100;
  // Reply port of every request, the master's own port
  localparam ctrl_pkg::ctrl_port_t MASTER_PORT = 10'd2;

  // One request with its expected answer
  typedef struct packed {
    ctrl_pkg::ctrl_req_t    req;
    ctrl_pkg::ctrl_status_t exp_status;
    ctrl_pkg::ctrl_word_t   exp_data;
  } vector_t;

  logic                 clk;
  logic                 rst;
  ctrl_pkg::ctrl_req_t  ctrl_req;
  ctrl_pkg::ctrl_resp_t ctrl_resp;

  vector_t vectors[$];
  int      pass_count  = 0;
  int      fail_count  = 0;
  int      cycles      = 0;
  int      cycle_limit = 0;

  ctrl_loopback_top ctrl_loopback_top_inst (
    .clk(clk),
    .rst(rst),
    .ctrl_req(ctrl_req),
    .ctrl_resp(ctrl_resp)
  );

  // 40 ns clock
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Watchdog, limit set once the vectors are known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: no ack from the DUT within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // Vector file
  // ------------------------------
  task automatic load_vectors();
    int          fd;
    int          n;
    string       text_line;
    logic [31:0] wr_f;
    logic [31:0] rd_f;
    logic [31:0] addr_f;
    logic [31:0] port_f;
    logic [31:0] epid_f;
    logic [31:0] data_f;
    logic [31:0] be_f;
    logic [31:0] ht_f;
    logic [63:0] time_f;
    logic [31:0] sts_f;
    logic [31:0] exp_f;
    vector_t     v;
    fd = $fopen("verification/ctrl_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test vector file verification/ctrl_testdata.txt");
      fail_count++;
    end else begin
      while ($fgets(text_line, fd) != 0) begin
        // Lines starting with # describe the columns
        if (text_line.len() > 0 && text_line[0] != "#") begin
          n = $sscanf(text_line, "%h %h %h %h %h %h %h %h %h %h %h",
                      wr_f, rd_f, addr_f, port_f, epid_f, data_f, be_f, ht_f,
                      time_f, sts_f, exp_f);
          if (n == 11) begin
            v                = '0;
            v.req.wr         = wr_f[0];
            v.req.rd         = rd_f[0];
            v.req.addr       = addr_f[19:0];
            v.req.portid     = port_f[9:0];
            v.req.rem_epid   = epid_f[15:0];
            v.req.rem_portid = MASTER_PORT;
            v.req.data       = data_f;
            v.req.byte_en    = be_f[3:0];
            v.req.has_time   = ht_f[0];
            v.req.timestamp  = time_f;
            v.exp_status     = sts_f[1:0];
            v.exp_data       = exp_f;
            vectors.push_back(v);
          end else if (n > 0) begin
            $display("Malformed vector line with %0d fields: %s", n, text_line);
            fail_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic string op_name(input logic wr, input logic rd);
    if (wr && rd) begin
      return "write-read";
    end else if (rd) begin
      return "read";
    end else begin
      return "write";
    end
  endfunction

  // ------------------------------
  // One transaction
  // ------------------------------
  // Strobe for one cycle on the falling edge, then wait for ack
  task automatic run_test(input int num, input vector_t v);
    ctrl_pkg::ctrl_resp_t got;
    logic                 ok;
    @(negedge clk);
    ctrl_req = v.req;
    @(negedge clk);
    ctrl_req.wr = 1'b0;
    ctrl_req.rd = 1'b0;
    while (!ctrl_resp.ack) begin
      @(negedge clk);
    end
    // Mid-cycle sample, ack and its fields are settled here
    got = ctrl_resp;
    ok  = 1'b1;
    assert (got.status == v.exp_status) else begin
      $display("mismatch ctrl_resp.status test %0d: got %h expected %h",
               num, got.status, v.exp_status);
      ok = 1'b0;
    end
    assert (got.data == v.exp_data) else begin
      $display("mismatch ctrl_resp.data test %0d: got %h expected %h",
               num, got.data, v.exp_data);
      ok = 1'b0;
    end
    // Ack is a single cycle pulse
    @(negedge clk);
    assert (!ctrl_resp.ack) else begin
      $display("Ack stayed high for more than one cycle in test %0d", num);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("test %0d %s addr %h port %h epid %h timed %0d status %h data %h %s",
             num, op_name(v.req.wr, v.req.rd), v.req.addr, v.req.portid,
             v.req.rem_epid, v.req.has_time, got.status, got.data,
             ok ? "ok" : "wrong");
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int num;
    ctrl_req = '0;
    rst      = 1'b1;
    num      = 0;
    load_vectors();
    cycle_limit = CYCLES_PER_TEST * NUM_PASSES * vectors.size() + CYCLE_MARGIN;
    // Reset held for 8 cycles, released on a falling edge
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int p = 0; p < NUM_PASSES; p++) begin
      foreach (vectors[i]) begin
        run_test(num, vectors[i]);
        num++;
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d", num, pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/ctrl_loopback_top.sv
// Loopback control path joining master, responder and register bank
`default_nettype none

module ctrl_loopback_top #(
  parameter ctrl_pkg::ctrl_port_t MASTER_PORTID = 10'd2,
  parameter ctrl_pkg::ctrl_epid_t LOCAL_EPID    = 16'h0010,
  parameter ctrl_pkg::ctrl_port_t LOCAL_PORTID  = 10'd5,
  parameter int                   NUM_REGS      = 16
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire ctrl_pkg::ctrl_req_t ctrl_req,
  output ctrl_pkg::ctrl_resp_t     ctrl_resp
);

  // ------------------------------
  // Stream links
  // ------------------------------
  ctrl_pkg::ctrl_stream_t req_stream;
  logic                   req_tready;
  ctrl_pkg::ctrl_stream_t resp_stream;
  logic                   resp_tready;

  // Register access
  logic                   reg_wr;
  logic                   reg_rd;
  ctrl_pkg::ctrl_addr_t   reg_addr;
  ctrl_pkg::ctrl_word_t   reg_wdata;
  logic [3:0]             reg_byte_en;
  ctrl_pkg::ctrl_word_t   reg_rdata;
  logic                   reg_ack;
  logic                   reg_err;

  ctrl_master #(
    .MASTER_PORTID(MASTER_PORTID)
  ) ctrl_master_inst (
    .clk(clk), .rst(rst),
    .req(ctrl_req), .resp(ctrl_resp),
    .req_stream(req_stream), .req_tready(req_tready),
    .resp_stream(resp_stream), .resp_tready(resp_tready)
  );

  ctrl_responder #(
    .LOCAL_EPID(LOCAL_EPID), .LOCAL_PORTID(LOCAL_PORTID), .NUM_REGS(NUM_REGS)
  ) ctrl_responder_inst (
    .clk(clk), .rst(rst),
    .req_stream(req_stream), .req_tready(req_tready),
    .resp_stream(resp_stream), .resp_tready(resp_tready),
    .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_byte_en(reg_byte_en),
    .reg_rdata(reg_rdata), .reg_ack(reg_ack), .reg_err(reg_err)
  );

  ctrl_reg_bank #(
    .NUM_REGS(NUM_REGS)
  ) ctrl_reg_bank_inst (
    .clk(clk), .rst(rst),
    .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_byte_en(reg_byte_en),
    .reg_rdata(reg_rdata), .reg_ack(reg_ack), .reg_err(reg_err)
  );

endmodule

`default_nettype wire

//--- src/ctrl_responder.sv
// Control responder that checks request packets, runs the register access and answers
`default_nettype none

module ctrl_responder #(
  parameter ctrl_pkg::ctrl_epid_t LOCAL_EPID   = 16'h0010,
  parameter ctrl_pkg::ctrl_port_t LOCAL_PORTID = 10'd5,
  parameter int                   NUM_REGS     = 16
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire ctrl_pkg::ctrl_stream_t req_stream,
  output logic                        req_tready,
  output ctrl_pkg::ctrl_stream_t      resp_stream,
  input  wire                         resp_tready,
  output logic                        reg_wr,
  output logic                        reg_rd,
  output ctrl_pkg::ctrl_addr_t        reg_addr,
  output ctrl_pkg::ctrl_word_t        reg_wdata,
  output logic [3:0]                  reg_byte_en,
  input  wire ctrl_pkg::ctrl_word_t   reg_rdata,
  input  wire                         reg_ack,
  input  wire                         reg_err
);

  ctrl_pkg::resp_state_t  state;
  logic                   req_ok;
  // Captured request fields
  ctrl_pkg::ctrl_port_t   dst_port;
  ctrl_pkg::ctrl_port_t   src_port;
  ctrl_pkg::ctrl_seq_t    seq_num;
  logic                   has_time;
  ctrl_pkg::ctrl_port_t   rem_port;
  ctrl_pkg::ctrl_epid_t   rem_epid;
  ctrl_pkg::ctrl_time_t   time_q;
  ctrl_pkg::ctrl_addr_t   addr_q;
  logic [3:0]             byte_en_q;
  ctrl_pkg::ctrl_opcode_t opcode_q;
  ctrl_pkg::ctrl_word_t   wdata_q;
  // Result
  ctrl_pkg::ctrl_status_t status_q;
  ctrl_pkg::ctrl_word_t   rdata_q;

  logic req_beat;
  logic resp_beat;

  assign req_beat  = req_stream.tvalid && req_tready;
  assign resp_beat = resp_stream.tvalid && resp_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ctrl_pkg::R_IDLE;
    end else begin
      case (state)
        ctrl_pkg::R_IDLE:   if (req_beat) state <= ctrl_pkg::R_HDR_HI;
        ctrl_pkg::R_HDR_HI: begin
          if (req_beat) state <= has_time ? ctrl_pkg::R_TS_LO : ctrl_pkg::R_OP;
        end
        ctrl_pkg::R_TS_LO:  if (req_beat) state <= ctrl_pkg::R_TS_HI;
        ctrl_pkg::R_TS_HI:  if (req_beat) state <= ctrl_pkg::R_OP;
        ctrl_pkg::R_OP:     if (req_beat) state <= ctrl_pkg::R_DATA;
        ctrl_pkg::R_DATA: begin
          // Misaddressed request skips the register access
          if (req_beat) state <= req_ok ? ctrl_pkg::R_ACCESS : ctrl_pkg::R_RESP_HDR_LO;
        end
        ctrl_pkg::R_ACCESS: state <= ctrl_pkg::R_WAIT;
        ctrl_pkg::R_WAIT:   state <= ctrl_pkg::R_RESP_HDR_LO;
        ctrl_pkg::R_RESP_HDR_LO: if (resp_beat) state <= ctrl_pkg::R_RESP_HDR_HI;
        ctrl_pkg::R_RESP_HDR_HI: begin
          if (resp_beat) state <= has_time ? ctrl_pkg::R_RESP_TS_LO : ctrl_pkg::R_RESP_OP;
        end
        ctrl_pkg::R_RESP_TS_LO: if (resp_beat) state <= ctrl_pkg::R_RESP_TS_HI;
        ctrl_pkg::R_RESP_TS_HI: if (resp_beat) state <= ctrl_pkg::R_RESP_OP;
        ctrl_pkg::R_RESP_OP:    if (resp_beat) state <= ctrl_pkg::R_RESP_DATA;
        ctrl_pkg::R_RESP_DATA:  if (resp_beat) state <= ctrl_pkg::R_IDLE;
        default: state <= ctrl_pkg::R_IDLE;
      endcase
    end
  end

  // Field capture, one word per state
  always_ff @(posedge clk) begin
    if (req_beat) begin
      case (state)
        ctrl_pkg::R_IDLE: begin
          dst_port <= req_stream.tdata[ctrl_pkg::HDR_DST_MSB:ctrl_pkg::HDR_DST_LSB];
          src_port <= req_stream.tdata[ctrl_pkg::HDR_SRC_MSB:ctrl_pkg::HDR_SRC_LSB];
          seq_num  <= req_stream.tdata[ctrl_pkg::HDR_SEQ_MSB:ctrl_pkg::HDR_SEQ_LSB];
          has_time <= req_stream.tdata[ctrl_pkg::HDR_HAS_TIME];
          req_ok   <= req_stream.tdata[ctrl_pkg::HDR_DST_MSB:ctrl_pkg::HDR_DST_LSB]
                      == LOCAL_PORTID;
        end
        ctrl_pkg::R_HDR_HI: begin
          rem_port <= req_stream.tdata[ctrl_pkg::HDR_REM_PORT_MSB:ctrl_pkg::HDR_REM_PORT_LSB];
          rem_epid <= req_stream.tdata[ctrl_pkg::HDR_REM_EPID_MSB:ctrl_pkg::HDR_REM_EPID_LSB];
          req_ok   <= req_ok && req_stream.tdata[ctrl_pkg::HDR_REM_EPID_MSB:
                                                 ctrl_pkg::HDR_REM_EPID_LSB] == LOCAL_EPID;
        end
        ctrl_pkg::R_TS_LO: time_q[31:0]  <= req_stream.tdata;
        ctrl_pkg::R_TS_HI: time_q[63:32] <= req_stream.tdata;
        ctrl_pkg::R_OP: begin
          addr_q    <= req_stream.tdata[ctrl_pkg::OPW_ADDR_MSB:ctrl_pkg::OPW_ADDR_LSB];
          byte_en_q <= req_stream.tdata[ctrl_pkg::OPW_BE_MSB:ctrl_pkg::OPW_BE_LSB];
          opcode_q  <= req_stream.tdata[ctrl_pkg::OPW_CODE_MSB:ctrl_pkg::OPW_CODE_LSB];
        end
        ctrl_pkg::R_DATA: begin
          wdata_q  <= req_stream.tdata;
          status_q <= ctrl_pkg::STS_CMDERR;
          rdata_q  <= '0;
        end
        default: ;
      endcase
    end
    // Bank answer, no ack means an unknown opcode
    if (state == ctrl_pkg::R_WAIT) begin
      if (!reg_ack || reg_err) begin
        status_q <= ctrl_pkg::STS_CMDERR;
        rdata_q  <= '0;
      end else begin
        status_q <= ctrl_pkg::STS_OKAY;
        rdata_q  <= (opcode_q == ctrl_pkg::OP_WRITE) ? wdata_q : reg_rdata;
      end
    end
  end

  assign req_tready = state inside {ctrl_pkg::R_IDLE, ctrl_pkg::R_HDR_HI, ctrl_pkg::R_TS_LO,
                                    ctrl_pkg::R_TS_HI, ctrl_pkg::R_OP, ctrl_pkg::R_DATA};

  // ------------------------------
  // Register strobes
  // ------------------------------
  assign reg_wr = (state == ctrl_pkg::R_ACCESS) &&
                  (opcode_q == ctrl_pkg::OP_WRITE || opcode_q == ctrl_pkg::OP_WRITE_READ);
  assign reg_rd = (state == ctrl_pkg::R_ACCESS) &&
                  (opcode_q == ctrl_pkg::OP_READ || opcode_q == ctrl_pkg::OP_WRITE_READ);
  assign reg_addr    = addr_q;
  assign reg_wdata   = wdata_q;
  assign reg_byte_en = byte_en_q;

  // ------------------------------
  // Response packet words
  // ------------------------------
  always_comb begin
    resp_stream.tdata  = '0;
    resp_stream.tvalid = 1'b1;
    resp_stream.tlast  = (state == ctrl_pkg::R_RESP_DATA);
    case (state)
      ctrl_pkg::R_RESP_HDR_LO: begin
        // Ports swapped for the way back
        resp_stream.tdata[ctrl_pkg::HDR_DST_MSB:ctrl_pkg::HDR_DST_LSB] = src_port;
        resp_stream.tdata[ctrl_pkg::HDR_SRC_MSB:ctrl_pkg::HDR_SRC_LSB] = dst_port;
        resp_stream.tdata[ctrl_pkg::HDR_NUM_MSB:ctrl_pkg::HDR_NUM_LSB] = 4'd1;
        resp_stream.tdata[ctrl_pkg::HDR_SEQ_MSB:ctrl_pkg::HDR_SEQ_LSB] = seq_num;
        resp_stream.tdata[ctrl_pkg::HDR_HAS_TIME] = has_time;
        resp_stream.tdata[ctrl_pkg::HDR_IS_ACK]   = 1'b1;
      end
      ctrl_pkg::R_RESP_HDR_HI: begin
        resp_stream.tdata[ctrl_pkg::HDR_REM_PORT_MSB:ctrl_pkg::HDR_REM_PORT_LSB] = rem_port;
        resp_stream.tdata[ctrl_pkg::HDR_REM_EPID_MSB:ctrl_pkg::HDR_REM_EPID_LSB] = rem_epid;
      end
      ctrl_pkg::R_RESP_TS_LO: resp_stream.tdata = time_q[31:0];
      ctrl_pkg::R_RESP_TS_HI: resp_stream.tdata = time_q[63:32];
      ctrl_pkg::R_RESP_OP: begin
        resp_stream.tdata[ctrl_pkg::OPW_ADDR_MSB:ctrl_pkg::OPW_ADDR_LSB] = addr_q;
        resp_stream.tdata[ctrl_pkg::OPW_BE_MSB:ctrl_pkg::OPW_BE_LSB]     = byte_en_q;
        resp_stream.tdata[ctrl_pkg::OPW_CODE_MSB:ctrl_pkg::OPW_CODE_LSB] = opcode_q;
        resp_stream.tdata[ctrl_pkg::OPW_STS_MSB:ctrl_pkg::OPW_STS_LSB]   = status_q;
      end
      ctrl_pkg::R_RESP_DATA: resp_stream.tdata = rdata_q;
      default: resp_stream.tvalid = 1'b0;
    endcase
  end

  // Bank answers exactly one cycle after a strobe
  a_reg_ack_next: assert property (@(posedge clk) disable iff (rst)
    reg_wr || reg_rd |=> reg_ack);

endmodule

`default_nettype wire

//--- src/ctrl_master.sv
// Control master turning port requests into request packets and responses into acks
`default_nettype none

module ctrl_master #(
  parameter ctrl_pkg::ctrl_port_t MASTER_PORTID = 10'd2
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire ctrl_pkg::ctrl_req_t req,
  output ctrl_pkg::ctrl_resp_t    resp,
  output ctrl_pkg::ctrl_stream_t  req_stream,
  input  wire                     req_tready,
  input  wire ctrl_pkg::ctrl_stream_t resp_stream,
  output logic                    resp_tready
);

  ctrl_pkg::master_state_t state;
  ctrl_pkg::ctrl_seq_t     seq_num;
  // Cached request
  ctrl_pkg::ctrl_req_t     req_q;
  ctrl_pkg::ctrl_opcode_t  opcode_q;
  // Response tracking
  logic                    resp_has_time;
  logic                    cmd_err;
  logic                    seq_err;
  ctrl_pkg::ctrl_status_t  resp_status;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ctrl_pkg::M_IDLE;
      seq_num <= '0;
    end else begin
      case (state)
        ctrl_pkg::M_IDLE: begin
          if (req.wr || req.rd) begin
            state <= ctrl_pkg::M_REQ_HDR_LO;
          end
        end
        ctrl_pkg::M_REQ_HDR_LO: if (req_tready) state <= ctrl_pkg::M_REQ_HDR_HI;
        ctrl_pkg::M_REQ_HDR_HI: begin
          if (req_tready) begin
            state <= req_q.has_time ? ctrl_pkg::M_REQ_TS_LO : ctrl_pkg::M_REQ_OP;
          end
        end
        ctrl_pkg::M_REQ_TS_LO: if (req_tready) state <= ctrl_pkg::M_REQ_TS_HI;
        ctrl_pkg::M_REQ_TS_HI: if (req_tready) state <= ctrl_pkg::M_REQ_OP;
        ctrl_pkg::M_REQ_OP:    if (req_tready) state <= ctrl_pkg::M_REQ_DATA;
        ctrl_pkg::M_REQ_DATA:  if (req_tready) state <= ctrl_pkg::M_RESP_HDR_LO;
        ctrl_pkg::M_RESP_HDR_LO: begin
          if (resp_stream.tvalid) state <= ctrl_pkg::M_RESP_HDR_HI;
        end
        ctrl_pkg::M_RESP_HDR_HI: begin
          if (resp_stream.tvalid) begin
            state <= resp_has_time ? ctrl_pkg::M_RESP_TS_LO : ctrl_pkg::M_RESP_OP;
          end
        end
        ctrl_pkg::M_RESP_TS_LO: if (resp_stream.tvalid) state <= ctrl_pkg::M_RESP_TS_HI;
        ctrl_pkg::M_RESP_TS_HI: if (resp_stream.tvalid) state <= ctrl_pkg::M_RESP_OP;
        ctrl_pkg::M_RESP_OP:    if (resp_stream.tvalid) state <= ctrl_pkg::M_RESP_DATA;
        ctrl_pkg::M_RESP_DATA: begin
          // Transaction done, next request uses the next sequence number
          if (resp_stream.tvalid) begin
            state   <= ctrl_pkg::M_IDLE;
            seq_num <= seq_num + 6'd1;
          end
        end
        default: state <= ctrl_pkg::M_IDLE;
      endcase
    end
  end

  // Request cache and response checks
  always_ff @(posedge clk) begin
    if (state == ctrl_pkg::M_IDLE && (req.wr || req.rd)) begin
      req_q <= req;
      if (req.wr && req.rd) opcode_q <= ctrl_pkg::OP_WRITE_READ;
      else if (req.rd)      opcode_q <= ctrl_pkg::OP_READ;
      else                  opcode_q <= ctrl_pkg::OP_WRITE;
    end
    if (state == ctrl_pkg::M_RESP_HDR_LO && resp_stream.tvalid) begin
      resp_has_time <= resp_stream.tdata[ctrl_pkg::HDR_HAS_TIME];
      seq_err <= resp_stream.tdata[ctrl_pkg::HDR_SEQ_MSB:ctrl_pkg::HDR_SEQ_LSB] != seq_num;
      cmd_err <= resp_stream.tdata[ctrl_pkg::HDR_DST_MSB:ctrl_pkg::HDR_DST_LSB]
                 != MASTER_PORTID;
    end
    if (state == ctrl_pkg::M_RESP_OP && resp_stream.tvalid) begin
      // Echoed opcode and address must match the request
      cmd_err <= cmd_err ||
                 resp_stream.tdata[ctrl_pkg::OPW_CODE_MSB:ctrl_pkg::OPW_CODE_LSB] != opcode_q ||
                 resp_stream.tdata[ctrl_pkg::OPW_ADDR_MSB:ctrl_pkg::OPW_ADDR_LSB] != req_q.addr;
      resp_status <= resp_stream.tdata[ctrl_pkg::OPW_STS_MSB:ctrl_pkg::OPW_STS_LSB];
    end
  end

  // ------------------------------
  // Request packet words
  // ------------------------------
  always_comb begin
    req_stream.tdata  = '0;
    req_stream.tvalid = 1'b1;
    req_stream.tlast  = (state == ctrl_pkg::M_REQ_DATA);
    case (state)
      ctrl_pkg::M_REQ_HDR_LO: begin
        req_stream.tdata[ctrl_pkg::HDR_DST_MSB:ctrl_pkg::HDR_DST_LSB] = req_q.portid;
        req_stream.tdata[ctrl_pkg::HDR_SRC_MSB:ctrl_pkg::HDR_SRC_LSB] = MASTER_PORTID;
        req_stream.tdata[ctrl_pkg::HDR_NUM_MSB:ctrl_pkg::HDR_NUM_LSB] = 4'd1;
        req_stream.tdata[ctrl_pkg::HDR_SEQ_MSB:ctrl_pkg::HDR_SEQ_LSB] = seq_num;
        req_stream.tdata[ctrl_pkg::HDR_HAS_TIME] = req_q.has_time;
      end
      ctrl_pkg::M_REQ_HDR_HI: begin
        req_stream.tdata[ctrl_pkg::HDR_REM_PORT_MSB:ctrl_pkg::HDR_REM_PORT_LSB] =
          req_q.rem_portid;
        req_stream.tdata[ctrl_pkg::HDR_REM_EPID_MSB:ctrl_pkg::HDR_REM_EPID_LSB] =
          req_q.rem_epid;
      end
      ctrl_pkg::M_REQ_TS_LO: req_stream.tdata = req_q.timestamp[31:0];
      ctrl_pkg::M_REQ_TS_HI: req_stream.tdata = req_q.timestamp[63:32];
      ctrl_pkg::M_REQ_OP: begin
        // Status field goes out as OKAY
        req_stream.tdata[ctrl_pkg::OPW_ADDR_MSB:ctrl_pkg::OPW_ADDR_LSB] = req_q.addr;
        req_stream.tdata[ctrl_pkg::OPW_BE_MSB:ctrl_pkg::OPW_BE_LSB]     = req_q.byte_en;
        req_stream.tdata[ctrl_pkg::OPW_CODE_MSB:ctrl_pkg::OPW_CODE_LSB] = opcode_q;
        req_stream.tdata[ctrl_pkg::OPW_STS_MSB:ctrl_pkg::OPW_STS_LSB]   = ctrl_pkg::STS_OKAY;
      end
      ctrl_pkg::M_REQ_DATA: req_stream.tdata = req_q.data;
      default: req_stream.tvalid = 1'b0;
    endcase
  end

  // Accept response words only after the request is out
  assign resp_tready = state inside {ctrl_pkg::M_RESP_HDR_LO, ctrl_pkg::M_RESP_HDR_HI,
                                     ctrl_pkg::M_RESP_TS_LO, ctrl_pkg::M_RESP_TS_HI,
                                     ctrl_pkg::M_RESP_OP, ctrl_pkg::M_RESP_DATA};

  // Ack on the data word, errors ranked CMDERR then WARNING
  always_comb begin
    resp.ack  = (state == ctrl_pkg::M_RESP_DATA) && resp_stream.tvalid;
    resp.data = resp_stream.tdata;
    if (cmd_err)      resp.status = ctrl_pkg::STS_CMDERR;
    else if (seq_err) resp.status = ctrl_pkg::STS_WARNING;
    else              resp.status = resp_status;
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // One outstanding request only
  a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
    state != ctrl_pkg::M_IDLE |-> !(req.wr || req.rd));

  // Response length is exact
  a_resp_tlast: assert property (@(posedge clk) disable iff (rst)
    resp_stream.tvalid && resp_tready |->
      resp_stream.tlast == (state == ctrl_pkg::M_RESP_DATA));

  a_req_stall_stable: assert property (@(posedge clk) disable iff (rst)
    req_stream.tvalid && !req_tready |=> req_stream.tvalid && $stable(req_stream.tdata));

endmodule

`default_nettype wire

//--- src/ctrl_reg_bank.sv
// Register bank with byte enabled writes and out of range detection
`default_nettype none

module ctrl_reg_bank #(
  parameter int NUM_REGS = 16
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       reg_wr,
  input  wire                       reg_rd,
  input  wire ctrl_pkg::ctrl_addr_t reg_addr,
  input  wire ctrl_pkg::ctrl_word_t reg_wdata,
  input  wire [3:0]                 reg_byte_en,
  output ctrl_pkg::ctrl_word_t      reg_rdata,
  output logic                      reg_ack,
  output logic                      reg_err
);

  localparam int IW = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  ctrl_pkg::ctrl_word_t regs [NUM_REGS];
  logic [17:0]          idx;
  logic                 in_range;
  ctrl_pkg::ctrl_word_t merged;

  // Word index and the post write value
  always_comb begin
    idx      = reg_addr[19:2];
    in_range = idx < NUM_REGS;
    merged   = in_range ? regs[idx[IW-1:0]] : '0;
    for (int b = 0; b < 4; b++) begin
      if (reg_wr && reg_byte_en[b]) merged[8*b +: 8] = reg_wdata[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
      reg_ack <= 1'b0;
      reg_err <= 1'b0;
    end else begin
      reg_ack <= reg_wr || reg_rd;
      reg_err <= (reg_wr || reg_rd) && !in_range;
      if (reg_wr && in_range) regs[idx[IW-1:0]] <= merged;
    end
  end

  // Read data sees the write of the same access
  always_ff @(posedge clk) reg_rdata <= merged;

  a_no_strobe_on_ack: assert property (@(posedge clk) disable iff (rst)
    reg_ack |-> !(reg_wr || reg_rd));

endmodule

`default_nettype wire

//--- src/ctrl_pkg.sv
// Control path package with stream widths, codes, packet field layout and FSM states
`default_nettype none

package ctrl_pkg;

  // ------------------------------
  // Widths with a meaning
  // ------------------------------
  typedef logic [31:0] ctrl_word_t;
  typedef logic [19:0] ctrl_addr_t;
  typedef logic [9:0]  ctrl_port_t;
  typedef logic [15:0] ctrl_epid_t;
  typedef logic [63:0] ctrl_time_t;
  typedef logic [5:0]  ctrl_seq_t;
  typedef logic [1:0]  ctrl_status_t;
  typedef logic [3:0]  ctrl_opcode_t;

  // Response status codes
  localparam ctrl_status_t STS_OKAY    = 2'd0;
  localparam ctrl_status_t STS_CMDERR  = 2'd1;
  localparam ctrl_status_t STS_TSERR   = 2'd2;
  localparam ctrl_status_t STS_WARNING = 2'd3;

  // Operation codes
  localparam ctrl_opcode_t OP_WRITE      = 4'd1;
  localparam ctrl_opcode_t OP_READ       = 4'd2;
  localparam ctrl_opcode_t OP_WRITE_READ = 4'd3;

  // ------------------------------
  // Packet field layout
  // ------------------------------
  // Header low word
  localparam int HDR_DST_LSB  = 0;
  localparam int HDR_DST_MSB  = 9;
  localparam int HDR_SRC_LSB  = 10;
  localparam int HDR_SRC_MSB  = 19;
  localparam int HDR_NUM_LSB  = 20;
  localparam int HDR_NUM_MSB  = 23;
  localparam int HDR_SEQ_LSB  = 24;
  localparam int HDR_SEQ_MSB  = 29;
  localparam int HDR_HAS_TIME = 30;
  localparam int HDR_IS_ACK   = 31;
  // Header high word
  localparam int HDR_REM_PORT_LSB = 0;
  localparam int HDR_REM_PORT_MSB = 9;
  localparam int HDR_REM_EPID_LSB = 10;
  localparam int HDR_REM_EPID_MSB = 25;
  // Operation word
  localparam int OPW_ADDR_LSB = 0;
  localparam int OPW_ADDR_MSB = 19;
  localparam int OPW_BE_LSB   = 20;
  localparam int OPW_BE_MSB   = 23;
  localparam int OPW_CODE_LSB = 24;
  localparam int OPW_CODE_MSB = 27;
  localparam int OPW_STS_LSB  = 30;
  localparam int OPW_STS_MSB  = 31;

  // ------------------------------
  // Bundles
  // ------------------------------
  typedef struct packed {
    logic       wr;
    logic       rd;
    ctrl_addr_t addr;
    ctrl_port_t portid;
    ctrl_epid_t rem_epid;
    ctrl_port_t rem_portid;
    ctrl_word_t data;
    logic [3:0] byte_en;
    logic       has_time;
    ctrl_time_t timestamp;
  } ctrl_req_t;

  typedef struct packed {
    logic         ack;
    ctrl_status_t status;
    ctrl_word_t   data;
  } ctrl_resp_t;

  // tready travels on its own in the opposite direction
  typedef struct packed {
    ctrl_word_t tdata;
    logic       tlast;
    logic       tvalid;
  } ctrl_stream_t;

  // ------------------------------
  // State machines
  // ------------------------------
  typedef enum logic [3:0] {
    M_IDLE, M_REQ_HDR_LO, M_REQ_HDR_HI, M_REQ_TS_LO, M_REQ_TS_HI, M_REQ_OP, M_REQ_DATA,
    M_RESP_HDR_LO, M_RESP_HDR_HI, M_RESP_TS_LO, M_RESP_TS_HI, M_RESP_OP, M_RESP_DATA
  } master_state_t;

  typedef enum logic [3:0] {
    R_IDLE, R_HDR_HI, R_TS_LO, R_TS_HI, R_OP, R_DATA, R_ACCESS, R_WAIT,
    R_RESP_HDR_LO, R_RESP_HDR_HI, R_RESP_TS_LO, R_RESP_TS_HI, R_RESP_OP, R_RESP_DATA
  } resp_state_t;

endpackage

`default_nettype wire
